// File: hw/mem_sys_consts.svh
`ifndef MEM_SYS_CONSTS_SVH
`define MEM_SYS_CONSTS_SVH

// memory map
`define SRAM_BASE 32'h8000_0000
// depth in 32-bit words
`define SRAM_WORDS 256
// uart data register, write only
`define UART_ADDR 32'h1000_0000

// sram wait cycles before the response
`define SRAM_LAT 2
// wait timer counter width
`define TIMER_W 4

// response codes
`define RESP_OKAY 2'b00
`define RESP_DECERR 2'b11

`endif

// File: hw/mem_sys_pkg.sv
package mem_sys_pkg;

	// byte address and bus word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	// one enable per byte lane
	typedef logic [3:0] strb_t;
	// okay / decerr
	typedef logic [1:0] resp_t;
	typedef logic [7:0] char_t;

	// arbiter fsm
	typedef enum logic [2:0] {
		ARB_IDLE,
		ARB_INST_RD,
		ARB_DATA_RD,
		ARB_DATA_WR,
		ARB_WR_RESP
	} arb_state_t;

	// crossbar targets
	typedef enum logic [1:0] {
		DEV_SRAM,
		DEV_UART,
		DEV_ERR
	} dev_t;

endpackage

// File: hw/axi_lite_if.sv
`timescale 1ns/1ps

interface axi_lite_if;
	import mem_sys_pkg::*;

	// read address
	addr_t ar_addr;
	logic  ar_valid;
	logic  ar_ready;
	// read data
	data_t r_data;
	resp_t r_resp;
	logic  r_valid;
	logic  r_ready;
	// write address
	addr_t aw_addr;
	logic  aw_valid;
	logic  aw_ready;
	// write data
	data_t w_data;
	strb_t w_strb;
	logic  w_valid;
	logic  w_ready;
	// write response
	resp_t b_resp;
	logic  b_valid;
	logic  b_ready;

	modport mgr (
		output ar_addr, ar_valid, r_ready, aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
		input  ar_ready, r_data, r_resp, r_valid, aw_ready, w_ready, b_resp, b_valid
	);

	modport sub (
		input  ar_addr, ar_valid, r_ready, aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
		output ar_ready, r_data, r_resp, r_valid, aw_ready, w_ready, b_resp, b_valid
	);

endinterface

// File: hw/wait_timer.sv
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module wait_timer (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                load_i,
	input  logic [`TIMER_W-1:0] count_i,
	output logic                done_o
);

	logic [`TIMER_W-1:0] cnt;
	// set by a load, cleared once done fires
	logic armed;

	assign done_o = armed && cnt == '0;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			cnt <= '0;
			armed <= 1'b0;
		end else if (load_i) begin
			cnt <= count_i;
			armed <= 1'b1;
		end else begin
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			if (done_o)
				armed <= 1'b0;
		end
	end

	// owner waits for expiry before reloading
	no_early_load: assert property (@(posedge clk) disable iff (rst_i) load_i |-> cnt == '0);

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                clk,
	input  logic                rst_i,
	input  mem_sys_pkg::addr_t  inst_ar_addr_i,
	input  logic                inst_ar_valid_i,
	output logic                inst_ar_ready_o,
	output mem_sys_pkg::data_t  inst_r_data_o,
	output mem_sys_pkg::resp_t  inst_r_resp_o,
	output logic                inst_r_valid_o,
	input  logic                inst_r_ready_i,
	input  mem_sys_pkg::addr_t  data_ar_addr_i,
	input  logic                data_ar_valid_i,
	output logic                data_ar_ready_o,
	output mem_sys_pkg::data_t  data_r_data_o,
	output mem_sys_pkg::resp_t  data_r_resp_o,
	output logic                data_r_valid_o,
	input  logic                data_r_ready_i,
	input  mem_sys_pkg::addr_t  data_aw_addr_i,
	input  logic                data_aw_valid_i,
	output logic                data_aw_ready_o,
	input  mem_sys_pkg::data_t  data_w_data_i,
	input  mem_sys_pkg::strb_t  data_w_strb_i,
	input  logic                data_w_valid_i,
	output logic                data_w_ready_o,
	output mem_sys_pkg::resp_t  data_b_resp_o,
	output logic                data_b_valid_o,
	input  logic                data_b_ready_i,
	axi_lite_if.mgr             bus_o
);
	import mem_sys_pkg::*;

	arb_state_t state;
	// 1 when the data port had the last grant
	logic last_data;
	// read address granted but not yet accepted downstream
	logic addr_pend;
	logic inst_req, data_wr_req, data_req;
	logic gnt_inst, gnt_data;
	logic inst_addr_ph, data_rd_addr_ph, wr_addr_ph;

	// a write needs both aw and w
	assign inst_req = inst_ar_valid_i;
	assign data_wr_req = data_aw_valid_i && data_w_valid_i;
	assign data_req = data_wr_req || data_ar_valid_i;

	// round robin, the port not served last wins a tie
	assign gnt_inst = inst_req && (!data_req || last_data);
	assign gnt_data = data_req && (!inst_req || !last_data);

	// which port owns the address channels this cycle
	assign inst_addr_ph = (state == ARB_IDLE && gnt_inst) || (state == ARB_INST_RD && addr_pend);
	assign data_rd_addr_ph = (state == ARB_IDLE && gnt_data && !data_wr_req) ||
		(state == ARB_DATA_RD && addr_pend);
	assign wr_addr_ph = (state == ARB_IDLE && gnt_data && data_wr_req) || state == ARB_DATA_WR;

	// shared bus, address side
	assign bus_o.ar_addr = inst_addr_ph ? inst_ar_addr_i : data_ar_addr_i;
	assign bus_o.ar_valid = (inst_addr_ph && inst_ar_valid_i) ||
		(data_rd_addr_ph && data_ar_valid_i);
	assign bus_o.aw_addr = data_aw_addr_i;
	assign bus_o.aw_valid = wr_addr_ph && data_aw_valid_i;
	assign bus_o.w_data = data_w_data_i;
	assign bus_o.w_strb = data_w_strb_i;
	assign bus_o.w_valid = wr_addr_ph && data_w_valid_i;

	// ready goes straight through to the owner, no extra cycle
	assign inst_ar_ready_o = inst_addr_ph && bus_o.ar_ready;
	assign data_ar_ready_o = data_rd_addr_ph && bus_o.ar_ready;
	assign data_aw_ready_o = wr_addr_ph && bus_o.aw_ready;
	assign data_w_ready_o = wr_addr_ph && bus_o.w_ready;

	// response steering, payload shared
	assign inst_r_data_o = bus_o.r_data;
	assign inst_r_resp_o = bus_o.r_resp;
	assign inst_r_valid_o = state == ARB_INST_RD && bus_o.r_valid;
	assign data_r_data_o = bus_o.r_data;
	assign data_r_resp_o = bus_o.r_resp;
	assign data_r_valid_o = state == ARB_DATA_RD && bus_o.r_valid;
	assign bus_o.r_ready = (state == ARB_INST_RD && inst_r_ready_i) ||
		(state == ARB_DATA_RD && data_r_ready_i);
	assign data_b_resp_o = bus_o.b_resp;
	assign data_b_valid_o = state == ARB_WR_RESP && bus_o.b_valid;
	assign bus_o.b_ready = state == ARB_WR_RESP && data_b_ready_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= ARB_IDLE;
			last_data <= 1'b0;
			addr_pend <= 1'b0;
		end else begin
			unique case (state)
				ARB_IDLE: begin
					if (gnt_inst) begin
						state <= ARB_INST_RD;
						last_data <= 1'b0;
						addr_pend <= !inst_ar_ready_o;
					end else if (gnt_data && data_wr_req) begin
						last_data <= 1'b1;
						// aw and w accepted together or wait for both
						state <= (data_aw_ready_o && data_w_ready_o) ? ARB_WR_RESP : ARB_DATA_WR;
					end else if (gnt_data) begin
						state <= ARB_DATA_RD;
						last_data <= 1'b1;
						addr_pend <= !data_ar_ready_o;
					end
				end
				ARB_INST_RD, ARB_DATA_RD: begin
					if (bus_o.ar_valid && bus_o.ar_ready)
						addr_pend <= 1'b0;
					if (bus_o.r_valid && bus_o.r_ready)
						state <= ARB_IDLE;
				end
				ARB_DATA_WR: begin
					if (data_aw_ready_o && data_w_ready_o)
						state <= ARB_WR_RESP;
				end
				ARB_WR_RESP: begin
					if (bus_o.b_valid && bus_o.b_ready)
						state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// only one port may see an address accepted per cycle
	one_grant: assert property (@(posedge clk) disable iff (rst_i)
		!(inst_ar_ready_o && (data_ar_ready_o || data_aw_ready_o)));

endmodule

// File: hw/addr_xbar.sv
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module addr_xbar (
	input  logic    clk,
	input  logic    rst_i,
	axi_lite_if.sub bus_i,
	axi_lite_if.mgr sram_o,
	axi_lite_if.mgr uart_o
);
	import mem_sys_pkg::*;

	localparam addr_t SRAM_END = `SRAM_BASE + `SRAM_WORDS * 4;

	dev_t rd_dev, wr_dev, cur_dev;
	// transaction outstanding at a target
	logic busy;
	logic cur_wr;
	// internal error responder
	logic err_valid;
	logic rd_go, wr_go, rsp_done;

	function automatic dev_t decode(input addr_t addr);
		if (addr >= `SRAM_BASE && addr < SRAM_END)
			return DEV_SRAM;
		if (addr == `UART_ADDR)
			return DEV_UART;
		return DEV_ERR;
	endfunction

	// uart is not readable, reads there fall to the error responder
	assign rd_dev = (decode(bus_i.ar_addr) == DEV_SRAM) ? DEV_SRAM : DEV_ERR;
	assign wr_dev = decode(bus_i.aw_addr);

	// payload broadcast, valid only to the decoded target
	assign sram_o.ar_addr = bus_i.ar_addr;
	assign sram_o.ar_valid = !busy && bus_i.ar_valid && rd_dev == DEV_SRAM;
	assign sram_o.aw_addr = bus_i.aw_addr;
	assign sram_o.aw_valid = !busy && bus_i.aw_valid && wr_dev == DEV_SRAM;
	assign sram_o.w_data = bus_i.w_data;
	assign sram_o.w_strb = bus_i.w_strb;
	assign sram_o.w_valid = !busy && bus_i.w_valid && wr_dev == DEV_SRAM;
	assign uart_o.ar_addr = bus_i.ar_addr;
	assign uart_o.ar_valid = 1'b0;
	assign uart_o.aw_addr = bus_i.aw_addr;
	assign uart_o.aw_valid = !busy && bus_i.aw_valid && wr_dev == DEV_UART;
	assign uart_o.w_data = bus_i.w_data;
	assign uart_o.w_strb = bus_i.w_strb;
	assign uart_o.w_valid = !busy && bus_i.w_valid && wr_dev == DEV_UART;

	// address ready from the target, error side takes aw and w together
	always_comb begin
		bus_i.ar_ready = 1'b0;
		bus_i.aw_ready = 1'b0;
		bus_i.w_ready = 1'b0;
		if (!busy) begin
			bus_i.ar_ready = (rd_dev == DEV_SRAM) ? sram_o.ar_ready : 1'b1;
			unique case (wr_dev)
				DEV_SRAM: begin
					bus_i.aw_ready = sram_o.aw_ready;
					bus_i.w_ready = sram_o.w_ready;
				end
				DEV_UART: begin
					bus_i.aw_ready = uart_o.aw_ready;
					bus_i.w_ready = uart_o.w_ready;
				end
				default: begin
					bus_i.aw_ready = bus_i.aw_valid && bus_i.w_valid;
					bus_i.w_ready = bus_i.aw_valid && bus_i.w_valid;
				end
			endcase
		end
	end

	// response comes back from the registered target only
	always_comb begin
		bus_i.r_valid = 1'b0;
		bus_i.r_data = '0;
		bus_i.r_resp = `RESP_DECERR;
		bus_i.b_valid = 1'b0;
		bus_i.b_resp = `RESP_DECERR;
		sram_o.r_ready = 1'b0;
		sram_o.b_ready = 1'b0;
		uart_o.r_ready = 1'b0;
		uart_o.b_ready = 1'b0;
		if (busy) begin
			unique case (cur_dev)
				DEV_SRAM: begin
					bus_i.r_valid = sram_o.r_valid;
					bus_i.r_data = sram_o.r_data;
					bus_i.r_resp = sram_o.r_resp;
					bus_i.b_valid = sram_o.b_valid;
					bus_i.b_resp = sram_o.b_resp;
					sram_o.r_ready = bus_i.r_ready;
					sram_o.b_ready = bus_i.b_ready;
				end
				DEV_UART: begin
					bus_i.b_valid = uart_o.b_valid;
					bus_i.b_resp = uart_o.b_resp;
					uart_o.b_ready = bus_i.b_ready;
				end
				default: begin
					bus_i.r_valid = err_valid && !cur_wr;
					bus_i.b_valid = err_valid && cur_wr;
				end
			endcase
		end
	end

	assign rd_go = bus_i.ar_valid && bus_i.ar_ready;
	assign wr_go = bus_i.aw_valid && bus_i.aw_ready;
	assign rsp_done = (bus_i.r_valid && bus_i.r_ready) || (bus_i.b_valid && bus_i.b_ready);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy <= 1'b0;
			cur_wr <= 1'b0;
			cur_dev <= DEV_ERR;
			err_valid <= 1'b0;
		end else if (rd_go || wr_go) begin
			busy <= 1'b1;
			cur_wr <= wr_go;
			cur_dev <= wr_go ? wr_dev : rd_dev;
			// error answer one cycle after the transfer
			err_valid <= (wr_go ? wr_dev : rd_dev) == DEV_ERR;
		end else if (rsp_done) begin
			busy <= 1'b0;
			err_valid <= 1'b0;
		end
	end

	// a device answers only for its own transaction
	sram_owner: assert property (@(posedge clk) disable iff (rst_i)
		(sram_o.r_valid || sram_o.b_valid) |-> busy && cur_dev == DEV_SRAM);
	uart_owner: assert property (@(posedge clk) disable iff (rst_i)
		uart_o.b_valid |-> busy && cur_dev == DEV_UART);

endmodule

// File: hw/sram_slave.sv
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module sram_slave (
	input  logic    clk,
	input  logic    rst_i,
	axi_lite_if.sub bus_i
);
	import mem_sys_pkg::*;

	localparam int IDX_W = $clog2(`SRAM_WORDS);
	localparam logic [`TIMER_W-1:0] LAT = `SRAM_LAT;

	data_t mem [`SRAM_WORDS];
	// word index of the pending read
	logic [IDX_W-1:0] idx_q;
	logic [IDX_W-1:0] rd_idx, wr_idx;
	logic busy, wr_q, hold_q;
	logic rd_go, wr_go, done, rsp_valid, rsp_take;

	// word index above the byte offset
	assign rd_idx = bus_i.ar_addr[IDX_W+1:2];
	assign wr_idx = bus_i.aw_addr[IDX_W+1:2];

	// one access at a time, write wins
	assign bus_i.aw_ready = !busy && bus_i.aw_valid && bus_i.w_valid;
	assign bus_i.w_ready = bus_i.aw_ready;
	assign bus_i.ar_ready = !busy && !bus_i.aw_valid;
	assign rd_go = bus_i.ar_valid && bus_i.ar_ready;
	assign wr_go = bus_i.aw_valid && bus_i.aw_ready;

	// access latency
	wait_timer u_timer (
		.clk     (clk),
		.rst_i   (rst_i),
		.load_i  (rd_go || wr_go),
		.count_i (LAT),
		.done_o  (done)
	);

	// byte lanes written as enabled
	always_ff @(posedge clk) begin
		if (wr_go) begin
			for (int b = 0; b < 4; b++) begin
				if (bus_i.w_strb[b])
					mem[wr_idx][8*b +: 8] <= bus_i.w_data[8*b +: 8];
			end
		end
		if (rd_go)
			idx_q <= rd_idx;
	end

	// valid from timer expiry, held until taken
	assign rsp_valid = done || hold_q;
	assign rsp_take = wr_q ? bus_i.b_ready : bus_i.r_ready;
	assign bus_i.r_valid = rsp_valid && !wr_q;
	assign bus_i.r_data = mem[idx_q];
	assign bus_i.r_resp = `RESP_OKAY;
	assign bus_i.b_valid = rsp_valid && wr_q;
	assign bus_i.b_resp = `RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy <= 1'b0;
			wr_q <= 1'b0;
			hold_q <= 1'b0;
		end else begin
			hold_q <= rsp_valid && !rsp_take;
			if (rd_go || wr_go) begin
				busy <= 1'b1;
				wr_q <= wr_go;
			end else if (rsp_valid && rsp_take) begin
				busy <= 1'b0;
			end
		end
	end

	r_held: assert property (@(posedge clk) disable iff (rst_i)
		bus_i.r_valid && !bus_i.r_ready |=> bus_i.r_valid);

endmodule

// File: hw/uart_sink.sv
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module uart_sink (
	input  logic               clk,
	input  logic               rst_i,
	axi_lite_if.sub            bus_i,
	output mem_sys_pkg::char_t char_o,
	output logic               strobe_o
);

	logic b_valid_q;
	logic wr_go;

	// takes aw and w in one cycle, blocked while b is pending
	assign bus_i.aw_ready = !b_valid_q && bus_i.aw_valid && bus_i.w_valid;
	assign bus_i.w_ready = bus_i.aw_ready;
	assign wr_go = bus_i.aw_valid && bus_i.aw_ready;

	// no readable register
	assign bus_i.ar_ready = 1'b0;
	assign bus_i.r_valid = 1'b0;
	assign bus_i.r_data = '0;
	assign bus_i.r_resp = `RESP_DECERR;

	assign bus_i.b_valid = b_valid_q;
	assign bus_i.b_resp = `RESP_OKAY;

	// strobe and b_valid rise in the same cycle
	always_ff @(posedge clk) begin
		if (rst_i) begin
			b_valid_q <= 1'b0;
			strobe_o <= 1'b0;
		end else begin
			strobe_o <= wr_go;
			if (wr_go)
				b_valid_q <= 1'b1;
			else if (bus_i.b_ready)
				b_valid_q <= 1'b0;
		end
	end

	// low byte only
	always_ff @(posedge clk) begin
		if (wr_go)
			char_o <= bus_i.w_data[7:0];
	end

endmodule

// File: hw/mem_sys_top.sv
`timescale 1ns/1ps

module mem_sys_top (
	input  logic               clk,
	input  logic               rst_i,
	// instruction fetch, read only
	input  mem_sys_pkg::addr_t inst_ar_addr_i,
	input  logic               inst_ar_valid_i,
	output logic               inst_ar_ready_o,
	output mem_sys_pkg::data_t inst_r_data_o,
	output mem_sys_pkg::resp_t inst_r_resp_o,
	output logic               inst_r_valid_o,
	input  logic               inst_r_ready_i,
	// data port
	input  mem_sys_pkg::addr_t data_ar_addr_i,
	input  logic               data_ar_valid_i,
	output logic               data_ar_ready_o,
	output mem_sys_pkg::data_t data_r_data_o,
	output mem_sys_pkg::resp_t data_r_resp_o,
	output logic               data_r_valid_o,
	input  logic               data_r_ready_i,
	input  mem_sys_pkg::addr_t data_aw_addr_i,
	input  logic               data_aw_valid_i,
	output logic               data_aw_ready_o,
	input  mem_sys_pkg::data_t data_w_data_i,
	input  mem_sys_pkg::strb_t data_w_strb_i,
	input  logic               data_w_valid_i,
	output logic               data_w_ready_o,
	output mem_sys_pkg::resp_t data_b_resp_o,
	output logic               data_b_valid_o,
	input  logic               data_b_ready_i,
	// character sink
	output mem_sys_pkg::char_t uart_char_o,
	output logic               uart_strobe_o
);

	// arbiter to crossbar, crossbar to each device
	axi_lite_if bus_arb ();
	axi_lite_if bus_sram ();
	axi_lite_if bus_uart ();

	mem_arbiter u_arbiter (
		.clk             (clk),
		.rst_i           (rst_i),
		.inst_ar_addr_i  (inst_ar_addr_i),
		.inst_ar_valid_i (inst_ar_valid_i),
		.inst_ar_ready_o (inst_ar_ready_o),
		.inst_r_data_o   (inst_r_data_o),
		.inst_r_resp_o   (inst_r_resp_o),
		.inst_r_valid_o  (inst_r_valid_o),
		.inst_r_ready_i  (inst_r_ready_i),
		.data_ar_addr_i  (data_ar_addr_i),
		.data_ar_valid_i (data_ar_valid_i),
		.data_ar_ready_o (data_ar_ready_o),
		.data_r_data_o   (data_r_data_o),
		.data_r_resp_o   (data_r_resp_o),
		.data_r_valid_o  (data_r_valid_o),
		.data_r_ready_i  (data_r_ready_i),
		.data_aw_addr_i  (data_aw_addr_i),
		.data_aw_valid_i (data_aw_valid_i),
		.data_aw_ready_o (data_aw_ready_o),
		.data_w_data_i   (data_w_data_i),
		.data_w_strb_i   (data_w_strb_i),
		.data_w_valid_i  (data_w_valid_i),
		.data_w_ready_o  (data_w_ready_o),
		.data_b_resp_o   (data_b_resp_o),
		.data_b_valid_o  (data_b_valid_o),
		.data_b_ready_i  (data_b_ready_i),
		.bus_o           (bus_arb)
	);

	addr_xbar u_xbar (
		.clk    (clk),
		.rst_i  (rst_i),
		.bus_i  (bus_arb),
		.sram_o (bus_sram),
		.uart_o (bus_uart)
	);

	sram_slave u_sram (
		.clk   (clk),
		.rst_i (rst_i),
		.bus_i (bus_sram)
	);

	uart_sink u_uart (
		.clk      (clk),
		.rst_i    (rst_i),
		.bus_i    (bus_uart),
		.char_o   (uart_char_o),
		.strobe_o (uart_strobe_o)
	);

endmodule

// File: dv/mem_sys_tb.sv
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module mem_sys_tb;
	import mem_sys_pkg::*;

	typedef logic [1:0] kind_t;
	localparam kind_t K_INST_RD = 2'd0;
	localparam kind_t K_DATA_RD = 2'd1;
	localparam kind_t K_DATA_WR = 2'd2;
	// inst read and data read issued in the same cycle
	localparam kind_t K_DUAL_RD = 2'd3;
	localparam int NUM_TESTS = 16;
	localparam addr_t SRAM_A = `SRAM_BASE;
	localparam addr_t UART_A = `UART_ADDR;
	// nothing mapped here
	localparam addr_t HOLE_A = 32'h2000_0000;

	// addr2 is the data port address of a dual read
	typedef struct packed {
		kind_t kind;
		addr_t addr;
		addr_t addr2;
		data_t wdata;
		strb_t strb;
		data_t exp_data;
		resp_t exp_resp;
	} entry_t;

	logic clk = 1'b0;
	logic rst_i;
	addr_t inst_ar_addr_i, data_ar_addr_i, data_aw_addr_i;
	data_t inst_r_data_o, data_r_data_o, data_w_data_i;
	resp_t inst_r_resp_o, data_r_resp_o, data_b_resp_o;
	strb_t data_w_strb_i;
	logic inst_ar_valid_i, inst_ar_ready_o, inst_r_valid_o, inst_r_ready_i;
	logic data_ar_valid_i, data_ar_ready_o, data_r_valid_o, data_r_ready_i;
	logic data_aw_valid_i, data_aw_ready_o, data_w_valid_i, data_w_ready_o;
	logic data_b_valid_o, data_b_ready_i;
	char_t uart_char_o;
	logic uart_strobe_o;

	entry_t tbl [NUM_TESTS];
	// expected sram contents
	data_t model [`SRAM_WORDS];
	integer seed = 32'h44f0;
	int errors = 0;
	int checks = 0;
	int strobe_cnt = 0;
	char_t last_char;

	mem_sys_top dut (.*);

	always #10 clk = ~clk;

	// count uart pulses and keep the char of the last one
	always @(posedge clk) begin
		if (uart_strobe_o) begin
			strobe_cnt <= strobe_cnt + 1;
			last_char <= uart_char_o;
		end
	end

	function automatic bit in_sram(input addr_t addr);
		return addr >= SRAM_A && addr < SRAM_A + `SRAM_WORDS * 4;
	endfunction

	function automatic int word_of(input addr_t addr);
		return int'((addr - SRAM_A) >> 2);
	endfunction

	// sram reads come from the model and the rest from the row
	function automatic data_t expect_read(input addr_t addr, input data_t row_data);
		return in_sram(addr) ? model[word_of(addr)] : row_data;
	endfunction

	// only enabled byte lanes change
	function automatic void model_write(input addr_t addr, input data_t wdata, input strb_t strb);
		int w;
		w = word_of(addr);
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				model[w][8*b +: 8] = wdata[8*b +: 8];
		end
	endfunction

	// 0 to 3 cycles of ready held low
	function automatic int backoff();
		return $random(seed) & 3;
	endfunction

	task automatic check_data(input string what, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input string what, input resp_t got, input resp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_char(input string what, input char_t got, input char_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// one read on the port that inst selects
	task automatic bus_read(input bit inst, input addr_t addr, output data_t data,
			output resp_t resp);
		int n;
		@(negedge clk);
		if (inst) begin
			inst_ar_addr_i = addr;
			inst_ar_valid_i = 1'b1;
		end else begin
			data_ar_addr_i = addr;
			data_ar_valid_i = 1'b1;
		end
		do @(posedge clk); while (!(inst ? inst_ar_ready_o : data_ar_ready_o));
		@(negedge clk);
		if (inst)
			inst_ar_valid_i = 1'b0;
		else
			data_ar_valid_i = 1'b0;
		do @(posedge clk); while (!(inst ? inst_r_valid_o : data_r_valid_o));
		n = backoff();
		repeat (n) @(posedge clk);
		@(negedge clk);
		if (inst)
			inst_r_ready_i = 1'b1;
		else
			data_r_ready_i = 1'b1;
		@(posedge clk);
		// response must survive the back-pressure
		if (!(inst ? inst_r_valid_o : data_r_valid_o)) begin
			errors++;
			$display("read response on the %s port went away before ready",
				inst ? "inst" : "data");
		end
		data = inst ? inst_r_data_o : data_r_data_o;
		resp = inst ? inst_r_resp_o : data_r_resp_o;
		@(negedge clk);
		inst_r_ready_i = inst ? 1'b0 : inst_r_ready_i;
		data_r_ready_i = inst ? data_r_ready_i : 1'b0;
	endtask

	// aw and w offered together and each dropped once taken
	task automatic data_write(input addr_t addr, input data_t wdata, input strb_t strb,
			output resp_t resp);
		int n;
		bit aw_done;
		bit w_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		@(negedge clk);
		data_aw_addr_i = addr;
		data_aw_valid_i = 1'b1;
		data_w_data_i = wdata;
		data_w_strb_i = strb;
		data_w_valid_i = 1'b1;
		while (!(aw_done && w_done)) begin
			@(posedge clk);
			aw_done = aw_done || data_aw_ready_o;
			w_done = w_done || data_w_ready_o;
			@(negedge clk);
			data_aw_valid_i = !aw_done;
			data_w_valid_i = !w_done;
		end
		do @(posedge clk); while (!data_b_valid_o);
		n = backoff();
		repeat (n) @(posedge clk);
		@(negedge clk);
		data_b_ready_i = 1'b1;
		@(posedge clk);
		if (!data_b_valid_o) begin
			errors++;
			$display("write response went away before ready");
		end
		resp = data_b_resp_o;
		@(negedge clk);
		data_b_ready_i = 1'b0;
	endtask

	task automatic fill_table();
		tbl[0] = '{K_DATA_WR, SRAM_A + 32'h10, 32'h0, 32'hdead_beef, 4'hf, 32'h0, `RESP_OKAY};
		tbl[1] = '{K_DATA_RD, SRAM_A + 32'h10, 32'h0, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
		// partial strobe on lanes 0 and 2
		tbl[2] = '{K_DATA_WR, SRAM_A + 32'h10, 32'h0, 32'h1122_3344, 4'h5, 32'h0, `RESP_OKAY};
		tbl[3] = '{K_DATA_RD, SRAM_A + 32'h10, 32'h0, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
		tbl[4] = '{K_DATA_WR, SRAM_A + 32'h40, 32'h0, 32'hcafe_f00d, 4'hf, 32'h0, `RESP_OKAY};
		tbl[5] = '{K_INST_RD, SRAM_A + 32'h40, 32'h0, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
		// uart takes the low byte only
		tbl[6] = '{K_DATA_WR, UART_A, 32'h0, 32'h1234_5641, 4'hf, 32'h0, `RESP_OKAY};
		tbl[7] = '{K_DATA_RD, UART_A, 32'h0, 32'h0, 4'h0, 32'h0, `RESP_DECERR};
		tbl[8] = '{K_DATA_WR, HOLE_A, 32'h0, 32'h5555_aaaa, 4'hf, 32'h0, `RESP_DECERR};
		tbl[9] = '{K_DATA_RD, HOLE_A + 32'h4, 32'h0, 32'h0, 4'h0, 32'h0, `RESP_DECERR};
		// last sram word
		tbl[10] = '{K_DATA_WR, SRAM_A + 32'h3fc, 32'h0, 32'h0bad_f00d, 4'hf, 32'h0, `RESP_OKAY};
		tbl[11] = '{K_INST_RD, 32'h0000_0100, 32'h0, 32'h0, 4'h0, 32'h0, `RESP_DECERR};
		// inst port went last, data port wins the tie
		tbl[12] = '{K_DUAL_RD, SRAM_A + 32'h40, SRAM_A + 32'h3fc, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
		tbl[13] = '{K_DATA_WR, SRAM_A + 32'h40, 32'h0, 32'h9988_7766, 4'ha, 32'h0, `RESP_OKAY};
		// data port went last, inst port wins the tie
		tbl[14] = '{K_DUAL_RD, SRAM_A + 32'h3fc, SRAM_A + 32'h40, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
		tbl[15] = '{K_DUAL_RD, SRAM_A + 32'h10, SRAM_A + 32'h10, 32'h0, 4'h0, 32'h0, `RESP_OKAY};
	endtask

	task automatic run_entry(input int i);
		entry_t e;
		data_t d1, d2;
		resp_t r1, r2;
		int errs_before;
		int pulses_before;
		int exp_pulses;
		e = tbl[i];
		errs_before = errors;
		pulses_before = strobe_cnt;
		case (e.kind)
			K_DATA_WR: begin
				data_write(e.addr, e.wdata, e.strb, r1);
				check_resp("write resp", r1, e.exp_resp);
				if (in_sram(e.addr))
					model_write(e.addr, e.wdata, e.strb);
			end
			K_INST_RD, K_DATA_RD: begin
				bus_read(e.kind == K_INST_RD, e.addr, d1, r1);
				check_data("read data", d1, expect_read(e.addr, e.exp_data));
				check_resp("read resp", r1, e.exp_resp);
			end
			default: begin
				// arbiter decides which one goes first
				fork
					bus_read(1'b1, e.addr, d1, r1);
					bus_read(1'b0, e.addr2, d2, r2);
				join
				check_data("inst read data", d1, expect_read(e.addr, e.exp_data));
				check_resp("inst read resp", r1, e.exp_resp);
				check_data("data read data", d2, expect_read(e.addr2, e.exp_data));
				check_resp("data read resp", r2, e.exp_resp);
			end
		endcase
		// one strobe per uart write and none otherwise
		exp_pulses = (e.kind == K_DATA_WR && e.addr == UART_A) ? 1 : 0;
		checks++;
		if (strobe_cnt - pulses_before != exp_pulses) begin
			errors++;
			$display("Fail %0t: %0d uart strobes, expected %0d", $time,
				strobe_cnt - pulses_before, exp_pulses);
		end
		if (exp_pulses == 1)
			check_char("uart char", last_char, e.wdata[7:0]);
		$display("test %0d: %s", i, (errors == errs_before) ? "ok" : "failed");
	endtask

	initial begin
		rst_i = 1'b1;
		inst_ar_addr_i = '0;
		inst_ar_valid_i = 1'b0;
		inst_r_ready_i = 1'b0;
		data_ar_addr_i = '0;
		data_ar_valid_i = 1'b0;
		data_r_ready_i = 1'b0;
		data_aw_addr_i = '0;
		data_aw_valid_i = 1'b0;
		data_w_data_i = '0;
		data_w_strb_i = '0;
		data_w_valid_i = 1'b0;
		data_b_ready_i = 1'b0;
		fill_table();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		for (int i = 0; i < NUM_TESTS; i++)
			run_entry(i);
		repeat (2) @(posedge clk);
		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// budget of 50 cycles per row
	initial begin
		#(NUM_TESTS * 50 * 20);
		$display("timeout: no progress after %0d clock cycles", NUM_TESTS * 50);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: mem_sys.f
+incdir+hw
hw/mem_sys_pkg.sv
hw/axi_lite_if.sv
hw/wait_timer.sv
hw/mem_arbiter.sv
hw/addr_xbar.sv
hw/sram_slave.sv
hw/uart_sink.sv
hw/mem_sys_top.sv
dv/mem_sys_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary -Wno-fatal --top-module mem_sys_tb -f mem_sys.f -Mdir obj_dir -o mem_sys_sim
	./obj_dir/mem_sys_sim | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
